//--- bench/lsuBusMem.sv
`timescale 1ns/100ps

module lsuBusMem import lsuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  adr_t     lsuBusAdr,
  input  logic     lsuBusRead,
  input  logic     lsuBusWrite,
  input  busSize_t lsuBusSize,
  input  word_t    lsuBusHwdata,
  output logic     lsuBusAck,
  output word_t    lsuBusHrdata
);

  localparam int Words = 64;
  localparam int LatencySlots = 64;

  word_t      mem [Words];
  logic [2:0] latencyTable [LatencySlots];
  logic [5:0] slot;
  logic [2:0] waited;
  logic [3:0] laneEn;
  logic [5:0] wordIdx;
  logic       strobe;
  int         seed;

  // every access gets its own latency of 1 to 4 cycles, drawn once up front
  initial begin
    seed = 32'hd83cce33;
    void'($urandom(seed));
    for (int i = 0; i < LatencySlots; i++) begin
      latencyTable[i] = 3'(1 + ($urandom % 4));
    end
  end

  assign strobe  = lsuBusRead | lsuBusWrite;
  assign wordIdx = lsuBusAdr[7:2];

  // byte enables follow from the low address bits and the size code
  always_comb begin
    case (lsuBusSize[1:0])
      sizeByte: laneEn = 4'b0001 << lsuBusAdr[1:0];
      sizeHalf: laneEn = lsuBusAdr[1] ? 4'b1100 : 4'b0011;
      default:  laneEn = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////
  // acknowledge and storage
  //////////////////////////////////////////////////

  // the ack is a one-cycle pulse, the strobe is still up in that cycle
  // so a new access is not started while the ack is high
  always_ff @(posedge clk) begin
    if (rst) begin
      lsuBusAck    <= 1'b0;
      lsuBusHrdata <= '0;
      waited       <= '0;
      slot         <= '0;
      for (int i = 0; i < Words; i++) begin
        mem[i] <= '0;
      end
    end else begin
      lsuBusAck <= 1'b0;
      if (strobe & ~lsuBusAck) begin
        if (waited + 3'd1 >= latencyTable[slot]) begin
          lsuBusAck    <= 1'b1;
          waited       <= '0;
          slot         <= slot + 6'd1;
          lsuBusHrdata <= mem[wordIdx];
          if (lsuBusWrite) begin
            for (int b = 0; b < 4; b++) begin
              if (laneEn[b]) begin
                mem[wordIdx][8*b +: 8] <= lsuBusHwdata[8*b +: 8];
              end
            end
          end
        end else begin
          waited <= waited + 3'd1;
        end
      end
    end
  end

endmodule

//--- bench/lsuTb.sv
`timescale 1ns/100ps

module lsuTb import lsuPkg::*; ();

  localparam int NumRows = 24;
  localparam int TimeoutCycles = 20 + 10 * NumRows;

  // drive delay after the rising edge
  localparam int DriveDelay = 10;

  localparam memRw_t  RwLoad  = 2'b10;
  localparam memRw_t  RwStore = 2'b01;
  localparam funct3_t F3Byte  = 3'b000;
  localparam funct3_t F3Half  = 3'b001;
  localparam funct3_t F3Word  = 3'b010;
  localparam funct3_t F3ByteU = 3'b100;
  localparam funct3_t F3HalfU = 3'b101;

  // fault bits are ordered load then store
  localparam logic [1:0] FaultNone  = 2'b00;
  localparam logic [1:0] FaultLoad  = 2'b10;
  localparam logic [1:0] FaultStore = 2'b01;

  // address presented in execute while a row waits, its word stays zero
  localparam adr_t StrayAdr = 32'h0000_0030;

  typedef struct packed {
    adr_t       adr;
    memRw_t     rw;
    funct3_t    funct3;
    word_t      writeData;
    logic [3:0] holdCycles;
    word_t      expRead;
    logic [1:0] expFault;
  } stimRow_t;

  logic     clk;
  logic     rst;
  logic     stallM;
  logic     flushM;
  adr_t     ieuAdrE;
  memRw_t   memRwM;
  funct3_t  funct3M;
  word_t    writeDataM;
  word_t    readDataM;
  logic     lsuStallM;
  logic     loadMisalignedFaultM;
  logic     storeMisalignedFaultM;
  adr_t     lsuBusAdr;
  logic     lsuBusRead;
  logic     lsuBusWrite;
  logic     lsuBusAck;
  word_t    lsuBusHrdata;
  word_t    lsuBusHwdata;
  busSize_t lsuBusSize;

  stimRow_t rows [NumRows];
  int       cycleCount = 0;

  lsu i_lsu (
    .clk, .rst, .stallM, .flushM, .lsuStallM,
    .ieuAdrE, .memRwM, .funct3M, .writeDataM, .readDataM,
    .loadMisalignedFaultM, .storeMisalignedFaultM,
    .lsuBusAdr, .lsuBusRead, .lsuBusWrite, .lsuBusAck,
    .lsuBusHrdata, .lsuBusHwdata, .lsuBusSize
  );

  lsuBusMem busMem (
    .clk, .rst, .lsuBusAdr, .lsuBusRead, .lsuBusWrite,
    .lsuBusSize, .lsuBusHwdata, .lsuBusAck, .lsuBusHrdata
  );

  always #50 clk = ~clk;

  // the whole table has to finish inside this many cycles
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > TimeoutCycles) begin
      $display("Timeout: the LSU did not finish the table within %0d cycles", TimeoutCycles);
      $display("Simulation finished: FAIL");
      $fatal(1, "run aborted by the cycle limit");
    end
  end

  task automatic checkValue(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic fillTable();
    // word store then word load, at two addresses
    rows[0]  = '{32'h10, RwStore, F3Word,  32'h1234_5678, 4'd0, 32'h0000_0000, FaultNone};
    rows[1]  = '{32'h24, RwStore, F3Word,  32'hcafe_f00d, 4'd0, 32'h0000_0000, FaultNone};
    rows[2]  = '{32'h10, RwLoad,  F3Word,  32'h0,         4'd0, 32'h1234_5678, FaultNone};
    rows[3]  = '{32'h24, RwLoad,  F3Word,  32'h0,         4'd0, 32'hcafe_f00d, FaultNone};
    // byte and halfword stores merge into the zero word at 0x20
    rows[4]  = '{32'h21, RwStore, F3Byte,  32'h0000_00a5, 4'd0, 32'h0000_0000, FaultNone};
    rows[5]  = '{32'h22, RwStore, F3Half,  32'h0000_beef, 4'd0, 32'h0000_0000, FaultNone};
    rows[6]  = '{32'h20, RwStore, F3Byte,  32'h0000_0011, 4'd0, 32'h0000_0000, FaultNone};
    rows[7]  = '{32'h20, RwLoad,  F3Word,  32'h0,         4'd0, 32'hbeef_a511, FaultNone};
    // subword loads from 0xbeefa511
    rows[8]  = '{32'h21, RwLoad,  F3Byte,  32'h0,         4'd0, 32'hffff_ffa5, FaultNone};
    rows[9]  = '{32'h21, RwLoad,  F3ByteU, 32'h0,         4'd0, 32'h0000_00a5, FaultNone};
    rows[10] = '{32'h22, RwLoad,  F3Half,  32'h0,         4'd0, 32'hffff_beef, FaultNone};
    rows[11] = '{32'h22, RwLoad,  F3HalfU, 32'h0,         4'd0, 32'h0000_beef, FaultNone};
    rows[12] = '{32'h20, RwLoad,  F3Half,  32'h0,         4'd0, 32'hffff_a511, FaultNone};
    rows[13] = '{32'h22, RwLoad,  F3Byte,  32'h0,         4'd0, 32'hffff_ffef, FaultNone};
    rows[14] = '{32'h23, RwLoad,  F3ByteU, 32'h0,         4'd0, 32'h0000_00be, FaultNone};
    // misaligned accesses fault and must not touch memory
    rows[15] = '{32'h12, RwStore, F3Word,  32'hffff_ffff, 4'd0, 32'h0000_0000, FaultStore};
    rows[16] = '{32'h21, RwLoad,  F3Half,  32'h0,         4'd0, 32'h0000_0000, FaultLoad};
    rows[17] = '{32'h13, RwStore, F3Half,  32'hffff_ffff, 4'd0, 32'h0000_0000, FaultStore};
    rows[18] = '{32'h11, RwLoad,  F3Word,  32'h0,         4'd0, 32'h0000_0000, FaultLoad};
    rows[19] = '{32'h10, RwLoad,  F3Word,  32'h0,         4'd0, 32'h1234_5678, FaultNone};
    rows[20] = '{32'h20, RwLoad,  F3Word,  32'h0,         4'd0, 32'hbeef_a511, FaultNone};
    // loads held in done by the core, then a load that must not see the stray address
    rows[21] = '{32'h24, RwLoad,  F3Word,  32'h0,         4'd3, 32'hcafe_f00d, FaultNone};
    rows[22] = '{32'h26, RwLoad,  F3HalfU, 32'h0,         4'd2, 32'h0000_cafe, FaultNone};
    rows[23] = '{32'h10, RwLoad,  F3Word,  32'h0,         4'd0, 32'h1234_5678, FaultNone};
  endtask

  // address in execute for one cycle, then the operation in memory
  task automatic applyRow(input stimRow_t row);
    int h;
    @(posedge clk);
    #DriveDelay;
    ieuAdrE    = row.adr;
    memRwM     = '0;
    funct3M    = '0;
    writeDataM = '0;
    @(posedge clk);
    #DriveDelay;
    memRwM     = row.rw;
    funct3M    = row.funct3;
    writeDataM = row.writeData;
    stallM     = (row.holdCycles != 0);
    if (row.expFault != FaultNone) begin
      // a faulting access keeps its address and sits in memory for two cycles
      // the FSM has to stay idle in both of them and never strobe the bus
      for (h = 0; h < 2; h++) begin
        @(negedge clk);
        checkValue("loadMisalignedFaultM", loadMisalignedFaultM, row.expFault[1]);
        checkValue("storeMisalignedFaultM", storeMisalignedFaultM, row.expFault[0]);
        checkValue("lsuStallM", lsuStallM, 1'b0);
        checkValue("lsuBusRead", lsuBusRead, 1'b0);
        checkValue("lsuBusWrite", lsuBusWrite, 1'b0);
      end
    end else begin
      ieuAdrE = StrayAdr;
      @(negedge clk);
      while (lsuStallM) begin
        @(negedge clk);
      end
      checkValue("loadMisalignedFaultM", loadMisalignedFaultM, 1'b0);
      checkValue("storeMisalignedFaultM", storeMisalignedFaultM, 1'b0);
      if (row.rw == RwLoad) begin
        checkValue("readDataM", readDataM, row.expRead);
      end
      // the core holds the done state, the load data must not move
      for (h = 0; h < row.holdCycles; h++) begin
        @(posedge clk);
        #DriveDelay;
        ieuAdrE = StrayAdr + adr_t'(h << 2);
        if (h == row.holdCycles - 1) begin
          stallM = 1'b0;
        end
        @(negedge clk);
        checkValue("lsuStallM", lsuStallM, 1'b0);
        if (row.rw == RwLoad) begin
          checkValue("readDataM", readDataM, row.expRead);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    stallM     = 1'b0;
    flushM     = 1'b0;
    ieuAdrE    = '0;
    memRwM     = '0;
    funct3M    = '0;
    writeDataM = '0;
    fillTable();
    repeat (5) @(posedge clk);
    #DriveDelay;
    rst = 1'b0;
    // nothing may move on the bus before the first request
    @(negedge clk);
    checkValue("lsuBusRead", lsuBusRead, 1'b0);
    checkValue("lsuBusWrite", lsuBusWrite, 1'b0);
    checkValue("lsuStallM", lsuStallM, 1'b0);
    for (int r = 0; r < NumRows; r++) begin
      applyRow(rows[r]);
    end
    @(posedge clk);
    #DriveDelay;
    memRwM  = '0;
    ieuAdrE = '0;
    @(negedge clk);
    checkValue("lsuStallM", lsuStallM, 1'b0);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- lsuLite.f
rtl/lsuPkg.sv
rtl/lsuSubwordWrite.sv
rtl/lsuAddrStage.sv
rtl/lsuBusCtrl.sv
rtl/lsuSubwordRead.sv
rtl/lsu.sv
bench/lsuBusMem.sv
bench/lsuTb.sv

//--- rtl/lsu.sv
`timescale 1ns/100ps

module lsu import lsuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  // core control
  input  logic     stallM,
  input  logic     flushM,
  output logic     lsuStallM,
  // core address and data
  input  adr_t     ieuAdrE,
  input  memRw_t   memRwM,
  input  funct3_t  funct3M,
  input  word_t    writeDataM,
  output word_t    readDataM,
  // faults to the trap logic
  output logic     loadMisalignedFaultM,
  output logic     storeMisalignedFaultM,
  // uncached word bus
  output adr_t     lsuBusAdr,
  output logic     lsuBusRead,
  output logic     lsuBusWrite,
  input  logic     lsuBusAck,
  input  word_t    lsuBusHrdata,
  output word_t    lsuBusHwdata,
  output busSize_t lsuBusSize
);

  lsuReq_t req;
  logic    misaligned;
  word_t   rdWord;

  //////////////////////////////////////////////////
  // address stage, bus controller, read extractor
  //////////////////////////////////////////////////

  // the bus stall is the only stall source, so it goes straight to the core
  lsuAddrStage i_lsuAddrStage (
    .clk, .rst, .stallM, .flushM,
    .busStall (lsuStallM),
    .ieuAdrE, .memRwM, .funct3M, .writeDataM,
    .req, .loadMisalignedFaultM, .storeMisalignedFaultM, .misaligned
  );

  lsuBusCtrl i_lsuBusCtrl (
    .clk, .rst, .stallM, .req, .misaligned,
    .lsuBusAck, .lsuBusHrdata,
    .busStall (lsuStallM),
    .lsuBusAdr, .lsuBusRead, .lsuBusWrite, .lsuBusSize, .lsuBusHwdata,
    .rdWord
  );

  // load data is formed from the captured word and the held request
  lsuSubwordRead i_lsuSubwordRead (
    .rdWord,
    .req,
    .readDataM
  );

endmodule

//--- rtl/lsuAddrStage.sv
`timescale 1ns/100ps

module lsuAddrStage import lsuPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    stallM,
  input  logic    flushM,
  input  logic    busStall,
  input  adr_t    ieuAdrE,
  input  memRw_t  memRwM,
  input  funct3_t funct3M,
  input  word_t   writeDataM,
  output lsuReq_t req,
  output logic    loadMisalignedFaultM,
  output logic    storeMisalignedFaultM,
  output logic    misaligned
);

  adr_t  adrM;
  word_t laneData;
  logic  adrEn;

  //////////////////////////////////////////////////
  // memory-stage address register
  //////////////////////////////////////////////////

  // the address advances only when neither the core nor the bus holds the pipe
  assign adrEn = ~stallM & ~busStall;

  // flush wins over the enable so a squashed access leaves a zero address
  always_ff @(posedge clk) begin
    if (rst) begin
      adrM <= '0;
    end else if (flushM) begin
      adrM <= '0;
    end else if (adrEn) begin
      adrM <= ieuAdrE;
    end
  end

  //////////////////////////////////////////////////
  // alignment check
  //////////////////////////////////////////////////

  // halfwords need bit 0 clear, words need both low bits clear
  // bytes are always aligned
  always_comb begin
    case (funct3M[1:0])
      sizeHalf: misaligned = adrM[0];
      sizeWord: misaligned = |adrM[1:0];
      default:  misaligned = 1'b0;
    endcase
  end

  // the fault follows the direction of the access in the memory stage
  // and is a level for as long as the instruction sits there
  assign loadMisalignedFaultM  = misaligned & memRwM[1];
  assign storeMisalignedFaultM = misaligned & memRwM[0];

  // store data is placed on the byte lanes before it reaches the bus
  lsuSubwordWrite i_lsuSubwordWrite (
    .funct3    (funct3M),
    .writeData (writeDataM),
    .laneData  (laneData)
  );

  // the control fields are already memory-stage signals from the core
  always_comb begin
    req.rw        = memRwM;
    req.funct3    = funct3M;
    req.adr       = adrM;
    req.writeData = laneData;
  end

endmodule

//--- rtl/lsuBusCtrl.sv
`timescale 1ns/100ps

module lsuBusCtrl import lsuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     stallM,
  input  lsuReq_t  req,
  input  logic     misaligned,
  input  logic     lsuBusAck,
  input  word_t    lsuBusHrdata,
  output logic     busStall,
  output adr_t     lsuBusAdr,
  output logic     lsuBusRead,
  output logic     lsuBusWrite,
  output busSize_t lsuBusSize,
  output word_t    lsuBusHwdata,
  output word_t    rdWord
);

  busState_e state;
  busState_e stateNext;
  logic      reqPresent;
  logic      inAccess;

  // a misaligned access is reported as a fault and never reaches the bus
  assign reqPresent = (req.rw != 2'b00) & ~misaligned;

  assign inAccess = (state == busAccess);

  //////////////////////////////////////////////////
  // access state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= busIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      // start the bus cycle on the edge after the request shows up
      busIdle: begin
        if (reqPresent) begin
          stateNext = busAccess;
        end
      end
      // wait for the memory, however long it takes
      busAccess: begin
        if (lsuBusAck) begin
          stateNext = busDone;
        end
      end
      // hold the result until the core lets the instruction move on
      busDone: begin
        if (~stallM) begin
          stateNext = busIdle;
        end
      end
      default: begin
        stateNext = busIdle;
      end
    endcase
  end

  // stall from the first cycle the request is seen until the ack
  // the done state releases the core so the load data can be consumed
  assign busStall = (state == busIdle & reqPresent) | inAccess;

  //////////////////////////////////////////////////
  // bus drive
  //////////////////////////////////////////////////

  // strobes are levels that stay up through the ack cycle
  assign lsuBusRead  = inAccess & req.rw[1];
  assign lsuBusWrite = inAccess & req.rw[0];

  // address, size and data are held stable by the stalled address register
  assign lsuBusAdr    = req.adr;
  assign lsuBusSize   = {1'b0, req.funct3[1:0]};
  assign lsuBusHwdata = req.writeData;

  //////////////////////////////////////////////////
  // read word capture
  //////////////////////////////////////////////////

  // hrdata is only valid in the ack cycle, so keep a copy for the done state
  always_ff @(posedge clk) begin
    if (inAccess & lsuBusAck) begin
      rdWord <= lsuBusHrdata;
    end
  end

endmodule

//--- rtl/lsuPkg.sv
package lsuPkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // data word width of the core, the LSU only supports RV32
  localparam int XLEN = 32;

  // a full data word as seen by the core and the bus
  typedef logic [XLEN-1:0] word_t;

  // byte address, physical and virtual are the same here
  typedef logic [XLEN-1:0] adr_t;

  // bit 1 requests a read and bit 0 requests a write
  // zero means the instruction in the memory stage does not touch memory
  typedef logic [1:0] memRw_t;

  // funct3 of the load or store, bit 2 selects zero extension
  // and bits 1:0 give the access size
  typedef logic [2:0] funct3_t;

  // size code on the bus, funct3 with the unsigned bit cleared
  typedef logic [2:0] busSize_t;

  // size codes found in funct3 bits 1:0
  localparam logic [1:0] sizeByte = 2'b00;
  localparam logic [1:0] sizeHalf = 2'b01;
  localparam logic [1:0] sizeWord = 2'b10;

  //////////////////////////////////////////////////
  // memory-stage request
  //////////////////////////////////////////////////

  // writeData is already replicated onto the byte lanes
  typedef struct packed {
    memRw_t  rw;
    funct3_t funct3;
    adr_t    adr;
    word_t   writeData;
  } lsuReq_t;

  // states of the uncached bus access controller
  typedef enum logic [1:0] {
    busIdle,
    busAccess,
    busDone
  } busState_e;

endpackage

//--- rtl/lsuSubwordRead.sv
`timescale 1ns/100ps

module lsuSubwordRead import lsuPkg::*; (
  input  word_t   rdWord,
  input  lsuReq_t req,
  output word_t   readDataM
);

  logic [7:0]  byteSel;
  logic [15:0] halfSel;
  logic        zeroExt;

  //////////////////////////////////////////////////
  // lane select
  //////////////////////////////////////////////////

  // the bus returns the whole aligned word, low address bits pick the lane
  always_comb begin
    case (req.adr[1:0])
      2'b00:   byteSel = rdWord[7:0];
      2'b01:   byteSel = rdWord[15:8];
      2'b10:   byteSel = rdWord[23:16];
      default: byteSel = rdWord[31:24];
    endcase
  end

  // only bit 1 matters for an aligned halfword
  assign halfSel = req.adr[1] ? rdWord[31:16] : rdWord[15:0];

  // lbu and lhu set funct3 bit 2
  assign zeroExt = req.funct3[2];

  //////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////

  always_comb begin
    case (req.funct3[1:0])
      sizeByte: begin
        readDataM = {{24{byteSel[7] & ~zeroExt}}, byteSel};
      end
      sizeHalf: begin
        readDataM = {{16{halfSel[15] & ~zeroExt}}, halfSel};
      end
      // words and the unused size code pass the full word
      default: begin
        readDataM = rdWord;
      end
    endcase
  end

  // the output is meaningful in the done state of the bus controller
  // and stays steady there because rdWord and the request are both held

endmodule

//--- rtl/lsuSubwordWrite.sv
`timescale 1ns/100ps

module lsuSubwordWrite import lsuPkg::*; (
  input  funct3_t funct3,
  input  word_t   writeData,
  output word_t   laneData
);

  // the bus memory picks the byte enables from address and size
  // so the data only has to be present on every lane it could land on

  //////////////////////////////////////////////////
  // lane replication
  //////////////////////////////////////////////////

  always_comb begin
    case (funct3[1:0])
      // a byte can land on any of the four lanes
      sizeByte: begin
        laneData = {4{writeData[7:0]}};
      end
      // a halfword lands on the lower or upper half
      sizeHalf: begin
        laneData = {2{writeData[15:0]}};
      end
      // full words go out unchanged
      default: begin
        laneData = writeData;
      end
    endcase
  end

  // the unsigned bit in funct3 has no meaning for a store
  // and the bus size code drops it as well

  // note that the lower lanes always carry the original data
  // which keeps a word store identical to the core's operand

endmodule
